// ==== design/uart_defines.svh ====
/*
 * Build-time constants for the UART: clock, baud rate and line levels.
 * Include wherever bit timing or line levels are needed.
 */

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

`define UART_CLK_FREQ 25_000_000  // system clock in Hz
`define UART_BIT_FREQ 1_562_500   // baud rate

// clocks per bit and per half bit
`define UART_BIT_PERIOD (`UART_CLK_FREQ / `UART_BIT_FREQ)
`define UART_HALF_BIT (`UART_BIT_PERIOD / 2)

// line levels
`define UART_START_BIT 1'b0  // start bit pulls line low
`define UART_STOP_BIT 1'b1   // stop bit and idle line are high

`endif

// ==== design/uart_pkg.sv ====
/*
 * Shared types for the UART blocks: character, counters, result structs
 * and state encodings. Referenced by scoped name only.
 */

`include "uart_defines.svh"

package uart_pkg;

  typedef logic [7:0] char_t;  // one character
  typedef logic [3:0] bit_count_t;  // position in frame, 0..10
  typedef logic [$clog2(`UART_BIT_PERIOD)-1:0] bit_timer_t;  // per-bit down-counter

  // receiver output toward the status block
  typedef struct packed {
    char_t data;  // last character received
    logic ready;  // one-cycle strobe, good character
    logic line_break;  // framing error level
  } rx_result_t;

  // host status word
  typedef struct packed {
    logic rx_valid;  // unread character held
    logic overrun;  // character lost before read
    logic line_break;  // last frame had a bad stop bit
    logic tx_busy;  // transmitter sending
  } uart_status_t;

  typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_stop, rx_holdoff} rx_state_t;
  typedef enum logic {tx_idle, tx_shift} tx_state_t;

endpackage

// ==== design/serial_rx.sv ====
/*
 * 8N1 character receiver. The async line goes through a 3-flop synchronizer,
 * each bit is sampled mid-bit, false starts are dropped and a bad stop bit
 * raises break followed by a half-bit hold-off.
 */

`timescale 1ns/1ps
`include "uart_defines.svh"

module serial_rx (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rx,  // async serial line
  output uart_pkg::rx_result_t   result
);

  localparam uart_pkg::bit_timer_t FULL_BIT_TIME = uart_pkg::bit_timer_t'(`UART_BIT_PERIOD - 1);
  localparam uart_pkg::bit_timer_t HALF_BIT_TIME = uart_pkg::bit_timer_t'(`UART_HALF_BIT - 1);

  logic [2:0]             sync_q;  // input synchronizer
  logic                   rx_line;  // synchronized line
  uart_pkg::rx_state_t    state;
  uart_pkg::bit_timer_t   timer;  // counts down to next sample
  uart_pkg::bit_count_t   bit_cnt;  // bits taken so far
  uart_pkg::char_t        data_q;  // shift register, LSB first
  logic                   ready_q;
  logic                   break_q;

  always_ff @(posedge clk)
  begin
    if (reset)
      sync_q <= '1;  // idle line is high
    else
      sync_q <= {sync_q[1:0], rx};
  end

  assign rx_line = sync_q[2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= uart_pkg::rx_idle;
      timer <= '0;
      bit_cnt <= '0;
      ready_q <= 1'b0;
      break_q <= 1'b0;
    end
    else
    begin
      ready_q <= 1'b0;  // strobe lasts one clock
      if (timer != '0)
        timer <= timer - 1'b1;  // wait for sample point
      else
      begin
        case (state)
          uart_pkg::rx_idle:
            if (rx_line == `UART_START_BIT)  // possible start edge
            begin
              timer <= HALF_BIT_TIME;
              state <= uart_pkg::rx_start;
            end
          uart_pkg::rx_start:
            if (rx_line != `UART_START_BIT)  // false start, drop it
              state <= uart_pkg::rx_idle;
            else
            begin
              timer <= FULL_BIT_TIME;
              bit_cnt <= 4'd1;  // start bit counted
              state <= uart_pkg::rx_data;
            end
          uart_pkg::rx_data:
          begin
            timer <= FULL_BIT_TIME;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd8)  // eighth data bit
              state <= uart_pkg::rx_stop;
          end
          uart_pkg::rx_stop:
          begin
            bit_cnt <= '0;
            if (rx_line == `UART_STOP_BIT)
            begin
              ready_q <= 1'b1;  // good character
              break_q <= 1'b0;
              state <= uart_pkg::rx_idle;
            end
            else
            begin
              break_q <= 1'b1;  // framing error, hold off half a bit
              timer <= HALF_BIT_TIME;
              state <= uart_pkg::rx_holdoff;
            end
          end
          default:  // hold-off done
            state <= uart_pkg::rx_idle;
        endcase
      end
    end
  end

  // data bits only, shifted in LSB first
  always_ff @(posedge clk)
  begin
    if (timer == '0 && state == uart_pkg::rx_data)
      data_q <= {rx_line, data_q[7:1]};
  end

  assign result = '{data: data_q, ready: ready_q, line_break: break_q};

  // ready is a single-cycle pulse per character
  assert property (@(posedge clk) disable iff (reset) ready_q |=> !ready_q);

  // frame position stays inside start, data and stop
  assert property (@(posedge clk) disable iff (reset) bit_cnt <= 4'd10);

endmodule

// ==== design/serial_tx.sv ====
/*
 * 8N1 character transmitter. A start strobe while idle loads one frame,
 * which goes out LSB first at one bit per bit period; busy covers the frame.
 */

`timescale 1ns/1ps
`include "uart_defines.svh"

module serial_tx (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,  // strobe, ignored while busy
  input  uart_pkg::char_t   data,
  output logic              tx,  // serial line
  output logic              busy
);

  localparam uart_pkg::bit_timer_t FULL_BIT_TIME = uart_pkg::bit_timer_t'(`UART_BIT_PERIOD - 1);

  uart_pkg::tx_state_t    state;
  uart_pkg::bit_timer_t   timer;  // clocks left in current bit
  uart_pkg::bit_count_t   bit_cnt;  // bit now on the line
  logic [9:0]             frame;  // bit 0 drives the line

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= uart_pkg::tx_idle;
      timer <= '0;
      bit_cnt <= '0;
      frame <= '1;  // line idles high
    end
    else
    begin
      case (state)
        uart_pkg::tx_idle:
          if (start)
          begin
            frame <= {`UART_STOP_BIT, data, `UART_START_BIT};
            timer <= FULL_BIT_TIME;
            bit_cnt <= '0;
            state <= uart_pkg::tx_shift;
          end
        default:
          if (timer != '0)
            timer <= timer - 1'b1;
          else if (bit_cnt == 4'd9)  // end of stop bit
            state <= uart_pkg::tx_idle;
          else
          begin
            frame <= {`UART_STOP_BIT, frame[9:1]};  // next bit, refill with stop level
            timer <= FULL_BIT_TIME;
            bit_cnt <= bit_cnt + 1'b1;
          end
      endcase
    end
  end

  assign tx = frame[0];
  assign busy = (state == uart_pkg::tx_shift);

  // line rests at the stop level between frames
  assert property (@(posedge clk) disable iff (reset) !busy |-> tx == `UART_STOP_BIT);

endmodule

// ==== design/uart_status.sv ====
/*
 * Host-side holding register and status word. Captures each received
 * character, flags overrun on an unread one and mirrors break and tx busy.
 */

`timescale 1ns/1ps

module uart_status (
  input  logic                   clk,
  input  logic                   reset,
  input  uart_pkg::rx_result_t   rx_result,
  input  logic                   tx_busy,
  input  logic                   read,  // host read strobe
  output uart_pkg::char_t        rx_data,
  output uart_pkg::uart_status_t status
);

  // holding register, loaded on each good character
  always_ff @(posedge clk)
  begin
    if (rx_result.ready)
      rx_data <= rx_result.data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      status <= '0;
    else
    begin
      status.line_break <= rx_result.line_break;
      status.tx_busy <= tx_busy;
      if (rx_result.ready)  // new char wins over a read
      begin
        status.rx_valid <= 1'b1;
        status.overrun <= (status.overrun | status.rx_valid) & ~read;  // lost one unless read now
      end
      else if (read)
      begin
        status.rx_valid <= 1'b0;
        status.overrun <= 1'b0;
      end
    end
  end

  // overrun only ever reported alongside a held character
  assert property (@(posedge clk) disable iff (reset) status.overrun |-> status.rx_valid);

endmodule

// ==== design/uart_top.sv ====
/*
 * UART top level. Receiver and transmitter run side by side and feed
 * the status block, which presents the host holding register and status.
 */

`timescale 1ns/1ps

module uart_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rx,  // async serial in
  output logic                    tx,  // serial out
  input  uart_pkg::char_t         tx_data,
  input  logic                    tx_start,
  input  logic                    rx_read,
  output uart_pkg::char_t         rx_data,
  output uart_pkg::uart_status_t  status
);

  uart_pkg::rx_result_t rx_result;  // receiver to status
  logic                 tx_busy;

  serial_rx rx_i (
    .clk    (clk),
    .reset  (reset),
    .rx     (rx),
    .result (rx_result)
  );

  serial_tx tx_i (
    .clk    (clk),
    .reset  (reset),
    .start  (tx_start),
    .data   (tx_data),
    .tx     (tx),
    .busy   (tx_busy)
  );

  uart_status status_i (
    .clk       (clk),
    .reset     (reset),
    .rx_result (rx_result),
    .tx_busy   (tx_busy),
    .read      (rx_read),
    .rx_data   (rx_data),
    .status    (status)
  );

endmodule

// ==== tests/uart_tb.sv ====
/*
 * Directed testbench for the UART top level. Drives serial frames on rx,
 * samples frames on tx at mid-bit and checks the host register and status.
 */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

  localparam int CLK_PERIOD = 40;  // ns
  localparam int FRAME_COUNT = 11;  // tx 4, rx 1, overrun 2, framing 2, false start 2
  localparam int TIMEOUT_NS = FRAME_COUNT * 10 * `UART_BIT_PERIOD * CLK_PERIOD + 40_000;
  localparam int WAIT_LIMIT = 12 * `UART_BIT_PERIOD;  // clocks before a wait gives up

  logic                   clk;
  logic                   reset;
  logic                   rx;
  logic                   tx;
  uart_pkg::char_t        tx_data;
  logic                   tx_start;
  logic                   rx_read;
  uart_pkg::char_t        rx_data;
  uart_pkg::uart_status_t status;
  logic [31:0]            rng_state;  // xorshift state
  int                     error_count;
  int                     check_count;
  int                     test_count;

  uart_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .rx       (rx),
    .tx       (tx),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .rx_read  (rx_read),
    .rx_data  (rx_data),
    .status   (status)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic uart_pkg::char_t next_char();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[7:0];
  endfunction

  function automatic uart_pkg::uart_status_t make_status(input logic v, input logic o,
                                                         input logic b, input logic t);
    uart_pkg::uart_status_t s;
    s.rx_valid = v;
    s.overrun = o;
    s.line_break = b;
    s.tx_busy = t;
    return s;
  endfunction

  task automatic check_char(input string name, input uart_pkg::char_t got,
                            input uart_pkg::char_t exp);
    check_count++;
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_status(input uart_pkg::uart_status_t got,
                              input uart_pkg::uart_status_t exp);
    check_count++;
    if (got !== exp)
    begin
      $display("Error: status got %h expected %h", got, exp);
      error_count++;
    end
  endtask

  task automatic check_line(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - errors_before);
  endtask

  // poll until the masked status bits match, plain-word failure otherwise
  task automatic wait_status(input uart_pkg::uart_status_t mask,
                             input uart_pkg::uart_status_t value);
    int n;
    n = 0;
    while ((status & mask) != value && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if ((status & mask) != value)
    begin
      $display("status bits %h did not reach %h within %0d clocks", mask, value, WAIT_LIMIT);
      error_count++;
    end
  endtask

  // one 8N1 frame on rx, each bit held a full bit period
  task automatic send_frame(input uart_pkg::char_t c, input logic stop_level);
    logic [9:0] bits;
    int i;
    bits = {stop_level, c, `UART_START_BIT};
    for (i = 0; i < 10; i++)
    begin
      @(negedge clk);
      rx = bits[i];
      repeat (`UART_BIT_PERIOD - 1) @(negedge clk);
    end
    @(negedge clk);
    rx = `UART_STOP_BIT;  // back to idle
  endtask

  // samples tx mid-bit, starting at the falling start edge
  task automatic capture_frame(output uart_pkg::char_t c);
    int n;
    int i;
    n = 0;
    c = '0;
    while (tx !== `UART_START_BIT && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== `UART_START_BIT)
    begin
      $display("no start bit appeared on tx");
      error_count++;
    end
    else
    begin
      repeat (`UART_HALF_BIT - 1) @(negedge clk);  // middle of start bit
      check_line("tx start bit", tx, `UART_START_BIT);
      check_status(status, make_status(0, 0, 0, 1));
      for (i = 0; i < 8; i++)
      begin
        repeat (`UART_BIT_PERIOD) @(negedge clk);
        c[i] = tx;  // LSB first
      end
      repeat (`UART_BIT_PERIOD) @(negedge clk);
      check_line("tx stop bit", tx, `UART_STOP_BIT);
    end
  endtask

  task automatic read_char();
    @(negedge clk);
    rx_read = 1'b1;
    @(negedge clk);
    rx_read = 1'b0;
  endtask

  // good frame in, held char checked, then read out
  task automatic receive_and_read(input uart_pkg::char_t c);
    send_frame(c, `UART_STOP_BIT);
    wait_status(make_status(1, 0, 0, 0), make_status(1, 0, 0, 0));
    check_char("rx_data", rx_data, c);
    check_status(status, make_status(1, 0, 0, 0));
    read_char();
    check_status(status, make_status(0, 0, 0, 0));
  endtask

  task automatic reset_values();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    check_line("tx", tx, `UART_STOP_BIT);
    check_status(status, make_status(0, 0, 0, 0));
    report_test("reset", errors_before);
  endtask

  task automatic transmit_chars();
    int errors_before;
    int n;
    uart_pkg::char_t c;
    uart_pkg::char_t got;
    errors_before = error_count;
    for (n = 0; n < 4; n++)
    begin
      c = next_char();
      @(negedge clk);
      tx_data = c;
      tx_start = 1'b1;
      @(negedge clk);
      tx_start = 1'b0;
      fork
        capture_frame(got);
        begin
          repeat (3 * `UART_BIT_PERIOD) @(negedge clk);  // strobe while busy
          tx_data = ~c;
          tx_start = 1'b1;
          @(negedge clk);
          tx_start = 1'b0;
        end
      join
      check_char("tx frame data", got, c);
      wait_status(make_status(0, 0, 0, 1), make_status(0, 0, 0, 0));
      check_status(status, make_status(0, 0, 0, 0));
      repeat (`UART_BIT_PERIOD)  // no second frame from the ignored strobe
      begin
        @(negedge clk);
        check_line("tx", tx, `UART_STOP_BIT);
      end
    end
    report_test("transmit", errors_before);
  endtask

  task automatic receive_char();
    int errors_before;
    errors_before = error_count;
    receive_and_read(next_char());
    report_test("receive", errors_before);
  endtask

  task automatic overrun_chars();
    int errors_before;
    uart_pkg::char_t first;
    uart_pkg::char_t second;
    errors_before = error_count;
    first = next_char();
    second = next_char();
    send_frame(first, `UART_STOP_BIT);
    wait_status(make_status(1, 0, 0, 0), make_status(1, 0, 0, 0));
    send_frame(second, `UART_STOP_BIT);  // lands on the unread one
    wait_status(make_status(0, 1, 0, 0), make_status(0, 1, 0, 0));
    check_char("rx_data", rx_data, second);
    check_status(status, make_status(1, 1, 0, 0));
    read_char();
    check_status(status, make_status(0, 0, 0, 0));
    report_test("overrun", errors_before);
  endtask

  task automatic framing_error();
    int errors_before;
    errors_before = error_count;
    send_frame(next_char(), ~`UART_STOP_BIT);  // low stop bit
    wait_status(make_status(0, 0, 1, 0), make_status(0, 0, 1, 0));
    check_status(status, make_status(0, 0, 1, 0));
    repeat (`UART_BIT_PERIOD) @(negedge clk);  // past the hold-off
    receive_and_read(next_char());  // clears break too
    report_test("framing", errors_before);
  endtask

  task automatic false_start();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    rx = `UART_START_BIT;
    repeat (`UART_BIT_PERIOD / 4 - 1) @(negedge clk);  // under a quarter bit
    rx = `UART_STOP_BIT;
    repeat (12 * `UART_BIT_PERIOD) @(negedge clk);  // a taken start would finish a frame by now
    check_status(status, make_status(0, 0, 0, 0));
    receive_and_read(next_char());
    report_test("false start", errors_before);
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    rx = `UART_STOP_BIT;
    tx_data = '0;
    tx_start = 1'b0;
    rx_read = 1'b0;
    rng_state = 32'd45557;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    reset_values();
    transmit_chars();
    receive_char();
    overrun_chars();
    framing_error();
    false_start();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== uart_top.f ====
+incdir+design
design/uart_pkg.sv
design/serial_rx.sv
design/serial_tx.sv
design/uart_status.sv
design/uart_top.sv
tests/uart_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the UART testbench

TOOL      = verilator
FLAGS     = --timing --assert
TOP       = uart_tb
FILE_LIST = uart_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run passes only if the log holds the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
